// ==== req_fifo.sv ====
`timescale 1ns/100ps

module req_fifo (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                push_i,
	input  tag_cache_pkg::req_t req_i,
	input  logic                pop_i,
	output tag_cache_pkg::req_t head_o,
	output logic                empty_o,
	output logic                full_o
);
	import tag_cache_pkg::*;

	typedef logic [PTR_BITS-1:0] ptr_t;
	typedef logic [OCC_BITS-1:0] occ_t;

	req_t mem [FIFO_DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	occ_t count;
	logic do_push;
	logic do_pop;

	// wraps at the last entry, depth need not be a power of two.
	function automatic ptr_t ptr_next(input ptr_t p);
		ptr_t n;
		if (p == ptr_t'(FIFO_DEPTH - 1))
			n = '0;
		else
			n = p + 1'b1;
		return n;
	endfunction

	assign empty_o = (count == '0);
	assign full_o  = (count == occ_t'(FIFO_DEPTH));

	assign do_push = push_i && !full_o;  // dropped when full.
	assign do_pop  = pop_i && !empty_o;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= req_i;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_next(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_next(rd_ptr);

			// push and pop together keep the count.
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// oldest entry, valid when not empty.
	assign head_o = mem[rd_ptr];

endmodule

// ==== result_router.sv ====
`timescale 1ns/100ps

module result_router (
	input  logic                      clk,
	input  logic                      rst_n,
	input  tag_cache_pkg::result_t    result_i,
	input  logic                      result_valid_i,

	output tag_cache_pkg::line_t      r_hit_data_o,
	output tag_cache_pkg::line_t      r_miss_data_o,
	output tag_cache_pkg::line_t      w_hit_data_o,
	output tag_cache_pkg::line_t      w_miss_data_o,

	output tag_cache_pkg::cls_mask_t  res_strobe_o,
	output tag_cache_pkg::req_id_t    res_id_o,
	output tag_cache_pkg::cnt_t       hit_cnt_o,
	output tag_cache_pkg::cnt_t       miss_cnt_o
);
	import tag_cache_pkg::*;

	line_t     port_q [NUM_CLS];  // indexed by class code.
	cls_mask_t strobe_q;
	req_id_t   id_q;
	cnt_t      hit_q;
	cnt_t      miss_q;
	logic      is_hit;

	assign is_hit = (result_i.cls == CLS_RHIT) || (result_i.cls == CLS_WHIT);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_CLS; i++)
				port_q[i] <= '0;
			strobe_q <= '0;
			id_q     <= '0;
			hit_q    <= '0;
			miss_q   <= '0;
		end else begin
			strobe_q <= '0;  // pulse lasts one cycle.
			if (result_valid_i) begin
				// selected port loads, the rest clear.
				for (int i = 0; i < NUM_CLS; i++)
					port_q[i] <= (result_i.cls == cls_t'(i)) ? result_i.data : '0;
				strobe_q <= cls_mask_t'(1) << result_i.cls;
				id_q     <= result_i.id;
				if (is_hit)
					hit_q <= hit_q + 1'b1;  // wraps.
				else
					miss_q <= miss_q + 1'b1;
			end
		end
	end

	assign r_hit_data_o  = port_q[CLS_RHIT];
	assign r_miss_data_o = port_q[CLS_RMISS];
	assign w_hit_data_o  = port_q[CLS_WHIT];
	assign w_miss_data_o = port_q[CLS_WMISS];

	assign res_strobe_o = strobe_q;
	assign res_id_o     = id_q;
	assign hit_cnt_o    = hit_q;
	assign miss_cnt_o   = miss_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# builds tb_tag_cache with Verilator and runs it once.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	-f tag_cache.f --top-module tb_tag_cache \
	--Mdir "$OBJ" -o Vtb_tag_cache
if [ $? -ne 0 ]; then
	echo "run_sim: verilator build failed"
	exit 1
fi

"./$OBJ/Vtb_tag_cache" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "run_sim: simulation exited with status $status"
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
	exit 0
fi
echo "run_sim: pass message not found in $LOG"
exit 1

// ==== tag_cache.f ====
tag_cache_pkg.sv
req_fifo.sv
tag_compare.sv
result_router.sv
tag_cache_top.sv
tag_cache_checker.sv
tb_tag_cache.sv

// ==== tag_cache_checker.sv ====
`timescale 1ns/100ps

module tag_cache_checker (
	input logic                     clk,
	input logic                     rst_n,
	input logic                     req_full_o,
	input logic                     rvalid_i,
	input logic                     rready_o,
	input tag_cache_pkg::line_t     r_hit_data_o,
	input tag_cache_pkg::line_t     r_miss_data_o,
	input tag_cache_pkg::line_t     w_hit_data_o,
	input tag_cache_pkg::line_t     w_miss_data_o,
	input tag_cache_pkg::cls_mask_t res_strobe_o,
	input tag_cache_pkg::cnt_t      hit_cnt_o,
	input tag_cache_pkg::cnt_t      miss_cnt_o
);

	logic accept;
	logic quiet;

	assign accept = rvalid_i && rready_o;
	assign quiet  = (res_strobe_o == '0) && !rready_o && !req_full_o &&
		(r_hit_data_o == '0) && (r_miss_data_o == '0) &&
		(w_hit_data_o == '0) && (w_miss_data_o == '0) &&
		(hit_cnt_o == '0) && (miss_cnt_o == '0);

	strobe_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(res_strobe_o))
		else $error("res_strobe_o has more than one bit set");

	// one beat per two cycles at most.
	ready_drops: assert property (@(posedge clk) disable iff (!rst_n)
		accept |=> !rready_o)
		else $error("rready_o high in the cycle after an acceptance");

	strobe_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
		(res_strobe_o != '0) |-> $past(accept, 2))
		else $error("strobe without an acceptance two edges earlier");

	reset_quiet: assert property (@(posedge clk) !rst_n |=> quiet)
		else $error("outputs not quiet during reset");

endmodule

bind tag_cache_top tag_cache_checker u_checker (
	.clk           (clk),
	.rst_n         (rst_n),
	.req_full_o    (req_full_o),
	.rvalid_i      (rvalid_i),
	.rready_o      (rready_o),
	.r_hit_data_o  (r_hit_data_o),
	.r_miss_data_o (r_miss_data_o),
	.w_hit_data_o  (w_hit_data_o),
	.w_miss_data_o (w_miss_data_o),
	.res_strobe_o  (res_strobe_o),
	.hit_cnt_o     (hit_cnt_o),
	.miss_cnt_o    (miss_cnt_o)
);

// ==== tag_cache_pkg.sv ====
package tag_cache_pkg;

	localparam int ADDR_BITS  = 64;
	localparam int INDEX_BITS = 8;   // set index, not part of the tag.
	localparam int TAG_BITS   = ADDR_BITS - INDEX_BITS;
	localparam int LINE_BITS  = 72;  // data word, ecc bits included.
	localparam int ID_BITS    = 16;
	localparam int CNT_BITS   = 16;
	localparam int NUM_CLS    = 4;

	localparam int FIFO_DEPTH = 4;
	localparam int PTR_BITS   = $clog2(FIFO_DEPTH);
	localparam int OCC_BITS   = $clog2(FIFO_DEPTH + 1);

	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [TAG_BITS-1:0]  tag_t;
	typedef logic [LINE_BITS-1:0] line_t;
	typedef logic [ID_BITS-1:0]   req_id_t;
	typedef logic [CNT_BITS-1:0]  cnt_t;
	typedef logic [1:0]           cls_t;
	typedef logic [NUM_CLS-1:0]   cls_mask_t;  // one bit per class code.

	localparam cls_t CLS_RHIT  = 2'd0;
	localparam cls_t CLS_RMISS = 2'd1;
	localparam cls_t CLS_WHIT  = 2'd2;
	localparam cls_t CLS_WMISS = 2'd3;

	// write flag on top, 81 bits in all.
	typedef struct packed {
		logic    is_write;
		req_id_t id;
		addr_t   addr;
	} req_t;

	typedef struct packed {
		cls_t    cls;
		req_id_t id;
		line_t   data;
	} result_t;

	typedef enum logic {CMP_IDLE, CMP_RESULT} cmp_state_e;

endpackage

// ==== tag_cache_top.sv ====
`timescale 1ns/100ps

module tag_cache_top (
	input  logic                      clk,
	input  logic                      rst_n,

	// request push side.
	input  logic                      req_push_i,
	input  tag_cache_pkg::req_t       req_i,
	output logic                      req_full_o,

	// R channel.
	input  tag_cache_pkg::line_t      rdata_i,
	input  tag_cache_pkg::tag_t       rtag_i,
	input  logic                      rvalid_i,
	output logic                      rready_o,

	output tag_cache_pkg::line_t      r_hit_data_o,
	output tag_cache_pkg::line_t      r_miss_data_o,
	output tag_cache_pkg::line_t      w_hit_data_o,
	output tag_cache_pkg::line_t      w_miss_data_o,

	output tag_cache_pkg::cls_mask_t  res_strobe_o,
	output tag_cache_pkg::req_id_t    res_id_o,
	output tag_cache_pkg::cnt_t       hit_cnt_o,
	output tag_cache_pkg::cnt_t       miss_cnt_o
);
	import tag_cache_pkg::*;

	req_t    head;
	logic    empty;
	logic    pop;
	result_t result;
	logic    result_valid;

	req_fifo u_req_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.push_i  (req_push_i),
		.req_i   (req_i),
		.pop_i   (pop),
		.head_o  (head),
		.empty_o (empty),
		.full_o  (req_full_o)
	);

	tag_compare u_tag_compare (
		.clk            (clk),
		.rst_n          (rst_n),
		.head_i         (head),
		.empty_i        (empty),
		.rdata_i        (rdata_i),
		.rtag_i         (rtag_i),
		.rvalid_i       (rvalid_i),
		.rready_o       (rready_o),
		.pop_o          (pop),
		.result_o       (result),
		.result_valid_o (result_valid)
	);

	result_router u_result_router (
		.clk            (clk),
		.rst_n          (rst_n),
		.result_i       (result),
		.result_valid_i (result_valid),
		.r_hit_data_o   (r_hit_data_o),
		.r_miss_data_o  (r_miss_data_o),
		.w_hit_data_o   (w_hit_data_o),
		.w_miss_data_o  (w_miss_data_o),
		.res_strobe_o   (res_strobe_o),
		.res_id_o       (res_id_o),
		.hit_cnt_o      (hit_cnt_o),
		.miss_cnt_o     (miss_cnt_o)
	);

endmodule

// ==== tag_compare.sv ====
`timescale 1ns/100ps

module tag_compare (
	input  logic                   clk,
	input  logic                   rst_n,

	// oldest queued request.
	input  tag_cache_pkg::req_t    head_i,
	input  logic                   empty_i,

	// R channel.
	input  tag_cache_pkg::line_t   rdata_i,
	input  tag_cache_pkg::tag_t    rtag_i,
	input  logic                   rvalid_i,
	output logic                   rready_o,

	output logic                   pop_o,
	output tag_cache_pkg::result_t result_o,
	output logic                   result_valid_o
);
	import tag_cache_pkg::*;

	cmp_state_e state;
	cmp_state_e state_n;
	tag_t       head_tag;
	logic       tag_match;
	logic       accept;
	cls_t       cls;
	result_t    result_q;

	assign head_tag  = head_i.addr[ADDR_BITS-1:INDEX_BITS];
	assign tag_match = (head_tag == rtag_i);

	// only take a beat when a request is there to pair it with.
	assign rready_o = (state == CMP_IDLE) && !empty_i;
	assign accept   = rvalid_i && rready_o;
	assign pop_o    = accept;

	always_comb begin
		case ({head_i.is_write, tag_match})
			2'b01: cls = CLS_RHIT;
			2'b00: cls = CLS_RMISS;
			2'b11: cls = CLS_WHIT;
			default: cls = CLS_WMISS;
		endcase
	end

	always_comb begin
		state_n = state;
		case (state)
			CMP_IDLE: begin
				if (accept)
					state_n = CMP_RESULT;
			end
			CMP_RESULT: begin
				state_n = CMP_IDLE;  // single result cycle.
			end
			default: begin
				state_n = CMP_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= CMP_IDLE;
		else
			state <= state_n;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			result_q.cls  <= cls;
			result_q.id   <= head_i.id;
			result_q.data <= rdata_i;  // word passes through unchanged.
		end
	end

	assign result_o       = result_q;
	assign result_valid_o = (state == CMP_RESULT);

endmodule

// ==== tb_tag_cache.sv ====
`timescale 1ns/100ps

module tb_tag_cache;
	import tag_cache_pkg::*;

	localparam int TIMEOUT_CYCLES = 20;

	logic      clk;
	logic      rst_n;
	logic      req_push_i;
	req_t      req_i;
	logic      req_full_o;
	line_t     rdata_i;
	tag_t      rtag_i;
	logic      rvalid_i;
	logic      rready_o;
	line_t     r_hit_data_o;
	line_t     r_miss_data_o;
	line_t     w_hit_data_o;
	line_t     w_miss_data_o;
	cls_mask_t res_strobe_o;
	req_id_t   res_id_o;
	cnt_t      hit_cnt_o;
	cnt_t      miss_cnt_o;

	integer  seed;
	int      cycle = 0;
	int      accept_cycle;
	int      exp_hits;
	int      exp_misses;
	req_id_t next_id;
	logic    reported;
	req_t    pending_q [$];  // requests the DUT should hold, oldest first.

	tag_cache_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	task automatic fail_and_stop();
		reported = 1'b1;
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic report_mismatch(input string what);
		$display("** Error at %0t ns: %s", $time, what);
		fail_and_stop();
	endtask

	task automatic report_timeout(input string what);
		$display("timeout after %0d cycles: %s", TIMEOUT_CYCLES, what);
		fail_and_stop();
	endtask

	function automatic line_t rand_line();
		return line_t'({$random(seed), $random(seed), $random(seed)});
	endfunction

	function automatic req_t make_req(input logic is_write);
		req_t r;
		r.is_write = is_write;
		r.id       = next_id;
		r.addr     = addr_t'({$random(seed), $random(seed)});
		next_id    = next_id + 1'b1;
		return r;
	endfunction

	function automatic tag_t tag_of(input addr_t addr);
		return addr[ADDR_BITS-1:INDEX_BITS];  // bits above the set index.
	endfunction

	function automatic cls_t class_of(input req_t r, input tag_t tag);
		logic hit;
		hit = (tag_of(r.addr) == tag);
		if (r.is_write)
			return hit ? CLS_WHIT : CLS_WMISS;
		return hit ? CLS_RHIT : CLS_RMISS;
	endfunction

	task automatic push_req(input req_t r);
		assert (req_full_o == (pending_q.size() == FIFO_DEPTH))
			else report_mismatch($sformatf("req_full_o %0b with %0d queued",
				req_full_o, pending_q.size()));
		req_i      = r;
		req_push_i = 1'b1;
		if (pending_q.size() < FIFO_DEPTH)
			pending_q.push_back(r);  // dropped when full.
		@(posedge clk);
		#1;
		req_push_i = 1'b0;
	endtask

	task automatic send_beat(input line_t data, input tag_t tag);
		int waited;
		waited   = 0;
		rdata_i  = data;
		rtag_i   = tag;
		rvalid_i = 1'b1;
		@(negedge clk);
		while (!rready_o) begin
			waited++;
			if (waited > TIMEOUT_CYCLES)
				report_timeout("R beat was never accepted");
			@(negedge clk);
		end
		@(posedge clk);  // acceptance edge.
		#1;
		accept_cycle = cycle;
		rvalid_i     = 1'b0;
	endtask

	task automatic expect_result(input line_t data, input tag_t tag);
		req_t      exp_req;
		cls_t      exp_cls;
		cls_mask_t exp_mask;
		line_t     got [NUM_CLS];
		int        waited;
		exp_req  = pending_q.pop_front();
		exp_cls  = class_of(exp_req, tag);
		exp_mask = '0;
		exp_mask[exp_cls] = 1'b1;
		if (exp_cls == CLS_RHIT || exp_cls == CLS_WHIT)
			exp_hits++;
		else
			exp_misses++;

		waited = 0;
		@(negedge clk);
		while (res_strobe_o == '0) begin
			waited++;
			if (waited > TIMEOUT_CYCLES)
				report_timeout("no result strobe after an accepted beat");
			@(negedge clk);
		end
		// registered twice, so it shows one cycle after the acceptance cycle.
		assert (cycle == accept_cycle + 1)
			else report_mismatch($sformatf("strobe in cycle %0d, acceptance in cycle %0d",
				cycle, accept_cycle));
		assert (res_strobe_o == exp_mask)
			else report_mismatch($sformatf("strobe %b, expected %b", res_strobe_o, exp_mask));
		assert (res_id_o == exp_req.id)
			else report_mismatch($sformatf("id %h, expected %h", res_id_o, exp_req.id));

		got[CLS_RHIT]  = r_hit_data_o;
		got[CLS_RMISS] = r_miss_data_o;
		got[CLS_WHIT]  = w_hit_data_o;
		got[CLS_WMISS] = w_miss_data_o;
		for (int i = 0; i < NUM_CLS; i++) begin
			assert (got[i] == ((i == exp_cls) ? data : line_t'(0)))
				else report_mismatch($sformatf("data port %0d holds %h", i, got[i]));
		end
		assert (hit_cnt_o == cnt_t'(exp_hits) && miss_cnt_o == cnt_t'(exp_misses))
			else report_mismatch($sformatf("counters %0d/%0d, expected %0d/%0d",
				hit_cnt_o, miss_cnt_o, exp_hits, exp_misses));

		@(negedge clk);
		assert (res_strobe_o == '0)
			else report_mismatch("strobe lasted more than one cycle");
		assert ((r_hit_data_o | r_miss_data_o | w_hit_data_o | w_miss_data_o) == data)
			else report_mismatch("selected port did not hold its value");
		@(posedge clk);
		#1;
	endtask

	// pairs a beat with the oldest pending request.
	task automatic serve_head(input logic hit);
		tag_t  tag;
		line_t data;
		tag = tag_of(pending_q[0].addr);
		if (!hit)
			tag = ~tag;  // every bit flipped, never matches.
		data = rand_line();
		send_beat(data, tag);
		expect_result(data, tag);
	endtask

	// caller sets up the R channel beforehand.
	task automatic check_no_result(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			assert (!rready_o && res_strobe_o == '0)
				else report_mismatch($sformatf("rready %0b strobe %b with no request queued",
					rready_o, res_strobe_o));
		end
		@(posedge clk);
		#1;
	endtask

	task automatic check_reset_state();
		assert (res_strobe_o == '0 && !rready_o && !req_full_o)
			else report_mismatch("control outputs not idle after reset");
		assert ((r_hit_data_o | r_miss_data_o | w_hit_data_o | w_miss_data_o) == '0)
			else report_mismatch("data ports not cleared by reset");
		assert (hit_cnt_o == '0 && miss_cnt_o == '0)
			else report_mismatch("counters not cleared by reset");
	endtask

	task automatic test_read();
		push_req(make_req(1'b0));
		serve_head(1'b1);
		push_req(make_req(1'b0));
		serve_head(1'b0);
	endtask

	task automatic test_write();
		push_req(make_req(1'b1));
		serve_head(1'b1);
		push_req(make_req(1'b1));
		serve_head(1'b0);
	endtask

	task automatic test_order();
		push_req(make_req(1'b0));
		push_req(make_req(1'b1));
		push_req(make_req(1'b0));
		push_req(make_req(1'b1));
		serve_head(1'b1);
		serve_head(1'b0);
		serve_head(1'b0);
		serve_head(1'b1);
	endtask

	task automatic test_backpressure();
		req_t  r;
		line_t data;
		tag_t  tag;
		r        = make_req(1'b0);
		tag      = tag_of(r.addr);
		data     = rand_line();
		rdata_i  = data;
		rtag_i   = tag;
		rvalid_i = 1'b1;
		check_no_result(10);
		push_req(r);
		send_beat(data, tag);  // same beat, still held.
		expect_result(data, tag);
	endtask

	task automatic test_full();
		repeat (FIFO_DEPTH + 1)
			push_req(make_req(1'b0));
		serve_head(1'b1);
		serve_head(1'b0);
		serve_head(1'b1);
		serve_head(1'b1);
		rdata_i  = rand_line();
		rvalid_i = 1'b1;
		check_no_result(5);
		rvalid_i = 1'b0;
	endtask

	initial begin
		seed         = 9;
		rst_n        = 1'b0;
		req_push_i   = 1'b0;
		req_i        = '0;
		rdata_i      = '0;
		rtag_i       = '0;
		rvalid_i     = 1'b0;
		next_id      = 16'h0a00;
		exp_hits     = 0;
		exp_misses   = 0;
		accept_cycle = 0;
		reported     = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;

		check_reset_state();
		test_read();
		test_write();
		test_order();
		test_backpressure();
		test_full();

		reported = 1'b1;
		$display("Simulation finished: PASS");
		$finish;
	end

	// a run stopped by the checker still ends with a verdict.
	final begin
		if (!reported)
			$display("Simulation finished: FAIL");
	end

endmodule
